/* Bender.yml */
package:
  name: sec_out_port

sources:
  - common/sec_out_pkg.sv
  - rtl/upsizer/axil_upsizer.sv
  - rtl/isolate/axil_isolate.sv
  - rtl/sec_out_port.sv
  - target: simulation
    files:
      - dv/tb_wide_mem.sv
      - dv/tb_sec_out_port.sv

/* all.f */
common/sec_out_pkg.sv
rtl/upsizer/axil_upsizer.sv
rtl/isolate/axil_isolate.sv
rtl/sec_out_port.sv
dv/tb_wide_mem.sv
dv/tb_sec_out_port.sv

/* dv/tb_sec_out_port.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the outbound port, random 32-bit traffic and
// isolate requests checked against a byte model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_sec_out_port;
   import sec_out_pkg::*;

   localparam logic [31:0] Seed      = 32'hb9514f24;
   localparam int unsigned NumTxn    = 2 + 400 + 4 + 200 + 16 + 2 + 8;
   localparam int unsigned MaxCycles = NumTxn * 20 + 500;

   logic         clk_i, reset_i, isolate_i, isolated_o;
   addr_t        s_axil_awaddr_i, s_axil_araddr_i;
   narrow_data_t s_axil_wdata_i, s_axil_rdata_o;
   narrow_strb_t s_axil_wstrb_i;
   resp_t        s_axil_bresp_o, s_axil_rresp_o;
   logic         s_axil_awvalid_i, s_axil_awready_o, s_axil_wvalid_i, s_axil_wready_o;
   logic         s_axil_bvalid_o, s_axil_bready_i, s_axil_arvalid_i, s_axil_arready_o;
   logic         s_axil_rvalid_o, s_axil_rready_i;
   addr_t        m_axil_awaddr_o, m_axil_araddr_o;
   wide_data_t   m_axil_wdata_o, m_axil_rdata_i;
   wide_strb_t   m_axil_wstrb_o;
   resp_t        m_axil_bresp_i, m_axil_rresp_i;
   logic         m_axil_awvalid_o, m_axil_awready_i, m_axil_wvalid_o, m_axil_wready_i;
   logic         m_axil_bvalid_i, m_axil_bready_o, m_axil_arvalid_o, m_axil_arready_i;
   logic         m_axil_rvalid_i, m_axil_rready_o;

   // Byte model and pending requests
   logic [7:0]   model [addr_t];
   addr_t        aw_q[$];
   addr_t        ar_q[$];
   narrow_data_t wd_q[$];
   narrow_strb_t ws_q[$];
   resp_t        exp_b_q[$];
   resp_t        exp_r_q[$];
   narrow_data_t exp_d_q[$];
   integer       seed;
   int unsigned  errors;
   int unsigned  cycles;
   bit           stall_up;

   sec_out_port #(.SyncStages(3), .MaxPending(8), .LaneDepth(8)) sec_out_port_i (.*);

   tb_wide_mem #(.Seed(Seed)) i_wide_mem (
      .clk_i, .reset_i,
      .awaddr_i (m_axil_awaddr_o), .awvalid_i(m_axil_awvalid_o), .awready_o(m_axil_awready_i),
      .wdata_i  (m_axil_wdata_o),  .wstrb_i  (m_axil_wstrb_o),
      .wvalid_i (m_axil_wvalid_o), .wready_o (m_axil_wready_i),
      .bresp_o  (m_axil_bresp_i),  .bvalid_o (m_axil_bvalid_i), .bready_i (m_axil_bready_o),
      .araddr_i (m_axil_araddr_o), .arvalid_i(m_axil_arvalid_o), .arready_o(m_axil_arready_i),
      .rdata_o  (m_axil_rdata_i),  .rresp_o  (m_axil_rresp_i),
      .rvalid_o (m_axil_rvalid_i), .rready_i (m_axil_rready_o)
   );

   initial clk_i = 1'b0;
   always #4 clk_i = ~clk_i;

   task automatic finish_run;
      $display("errors: %0d", errors);
      if (errors == 0) $display("TESTS PASSED");
      else $display("TESTS FAILED");
      $finish;
   endtask

   task automatic check_resp(string name, resp_t exp, resp_t act);
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_rdata(narrow_data_t exp, narrow_data_t act);
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t: s_axil_rdata_o expected %h, got %h", $time, exp, act);
      end
   endtask

   task automatic check_isolated(bit exp);
      if (isolated_o !== exp) begin
         errors++;
         $display("mismatch at %0t: isolated_o expected %b, got %b", $time, exp, isolated_o);
      end
   endtask

   function automatic narrow_data_t model_word(addr_t addr);
      narrow_data_t word;
      for (int i = 0; i < 4; i++) begin
         word[8*i +: 8] = model.exists(addr + i) ? model[addr + i] : 8'h00;
      end
      return word;
   endfunction

   // Word aligned, inside the 256-byte window
   function automatic addr_t rand_addr();
      return addr_t'($random(seed)) & 32'h0000_00fc;
   endfunction

   task automatic queue_write(addr_t addr, narrow_data_t data, narrow_strb_t strb, resp_t resp);
      aw_q.push_back(addr);
      wd_q.push_back(data);
      ws_q.push_back(strb);
      exp_b_q.push_back(resp);
      for (int i = 0; i < 4; i++) begin
         if (resp == RespOkay && strb[i]) model[addr + i] = data[8*i +: 8];
      end
   endtask

   task automatic queue_read(addr_t addr, resp_t resp);
      ar_q.push_back(addr);
      exp_r_q.push_back(resp);
      exp_d_q.push_back((resp == RespOkay) ? model_word(addr) : '0);
   endtask

   task automatic wait_idle;
      while (exp_b_q.size() != 0 || exp_r_q.size() != 0) @(negedge clk_i);
   endtask

   task automatic wait_accepted;
      while (aw_q.size() != 0 || wd_q.size() != 0 || ar_q.size() != 0) @(negedge clk_i);
   endtask

   // Fixed latency, SyncStages edges then one more for the FSM
   task automatic release_isolation;
      @(posedge clk_i);
      #1 isolate_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1 check_isolated(1'b1);
      @(posedge clk_i);
      #1 check_isolated(1'b0);
      @(negedge clk_i);
   endtask

   // Batches of writes, then reads of the same size
   task automatic random_traffic(int unsigned n_writes);
      int unsigned done;
      int unsigned n;
      done = 0;
      while (done < n_writes) begin
         n = 1 + $unsigned($random(seed)) % 8;
         if (n > n_writes - done) n = n_writes - done;
         for (int i = 0; i < n; i++) begin
            queue_write(rand_addr(), $random(seed), narrow_strb_t'($random(seed)), RespOkay);
         end
         wait_idle();
         for (int i = 0; i < n; i++) queue_read(rand_addr(), RespOkay);
         wait_idle();
         done += n;
      end
   endtask

   // Sample at the edge, drive 1 ns later
   always @(posedge clk_i) begin
      if (s_axil_awvalid_i && s_axil_awready_o) void'(aw_q.pop_front());
      if (s_axil_wvalid_i && s_axil_wready_o) begin
         void'(wd_q.pop_front());
         void'(ws_q.pop_front());
      end
      if (s_axil_arvalid_i && s_axil_arready_o) void'(ar_q.pop_front());
      if (s_axil_bvalid_o && s_axil_bready_i) begin
         if (exp_b_q.size() == 0) begin
            errors++;
            $display("write response at %0t with no write outstanding", $time);
         end else begin
            check_resp("s_axil_bresp_o", exp_b_q.pop_front(), s_axil_bresp_o);
         end
      end
      if (s_axil_rvalid_o && s_axil_rready_i) begin
         if (exp_r_q.size() == 0) begin
            errors++;
            $display("read response at %0t with no read outstanding", $time);
         end else begin
            check_resp("s_axil_rresp_o", exp_r_q.pop_front(), s_axil_rresp_o);
            check_rdata(exp_d_q.pop_front(), s_axil_rdata_o);
         end
      end
      #1;
      s_axil_awvalid_i = (aw_q.size() != 0);
      if (aw_q.size() != 0) s_axil_awaddr_i = aw_q[0];
      s_axil_wvalid_i = (wd_q.size() != 0);
      if (wd_q.size() != 0) begin
         s_axil_wdata_i = wd_q[0];
         s_axil_wstrb_i = ws_q[0];
      end
      s_axil_arvalid_i = (ar_q.size() != 0);
      if (ar_q.size() != 0) s_axil_araddr_i = ar_q[0];
      s_axil_bready_i = !reset_i && (!stall_up || ($random(seed) & 3) != 0);
      s_axil_rready_i = !reset_i && (!stall_up || ($random(seed) & 3) != 0);
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles >= MaxCycles) begin
         errors++;
         $display("timeout, run stopped after %0d cycles", cycles);
         finish_run();
      end
   end

   initial begin
      seed             = Seed;
      errors           = 0;
      cycles           = 0;
      stall_up         = 1'b0;
      reset_i          = 1'b1;
      isolate_i        = 1'b1;
      s_axil_awaddr_i  = '0;
      s_axil_awvalid_i = 1'b0;
      s_axil_wdata_i   = '0;
      s_axil_wstrb_i   = '0;
      s_axil_wvalid_i  = 1'b0;
      s_axil_bready_i  = 1'b0;
      s_axil_araddr_i  = '0;
      s_axil_arvalid_i = 1'b0;
      s_axil_rready_i  = 1'b0;
      repeat (16) @(posedge clk_i);
      #1 reset_i = 1'b0;

      // Out of reset the port answers locally
      @(negedge clk_i);
      check_isolated(1'b1);
      queue_write(32'h10, 32'hdead_beef, 4'hf, RespDecerr);
      queue_read(32'h10, RespDecerr);
      wait_idle();

      release_isolation();
      random_traffic(200);

      // Words differing only in bit 2 land in separate halves
      queue_write(32'h80, 32'h1111_2222, 4'hf, RespOkay);
      queue_write(32'h84, 32'h3333_4444, 4'hf, RespOkay);
      wait_idle();
      queue_read(32'h80, RespOkay);
      queue_read(32'h84, RespOkay);
      wait_idle();

      stall_up = 1'b1;
      random_traffic(100);

      // Isolate with traffic in flight
      for (int i = 0; i < 8; i++) queue_write(32'h200 + 4 * i, $random(seed), 4'hf, RespOkay);
      for (int i = 0; i < 8; i++) queue_read(rand_addr(), RespOkay);
      wait_accepted();
      @(posedge clk_i);
      #1 isolate_i = 1'b1;
      @(negedge clk_i);
      while (!isolated_o) @(negedge clk_i);
      if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
         errors++;
         $display("isolated_o rose at %0t with responses still outstanding", $time);
      end
      queue_write(32'h204, 32'hcafe_f00d, 4'hf, RespDecerr);
      queue_read(32'h204, RespDecerr);
      wait_idle();
      release_isolation();
      for (int i = 0; i < 8; i++) queue_read(32'h200 + 4 * i, RespOkay);
      wait_idle();
      finish_run();
   end

endmodule

/* dv/tb_wide_mem.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64-bit AXI4-Lite memory with random stalls, stands in for
// the host system behind the outbound port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_wide_mem #(
   parameter logic [31:0] Seed = 32'hb9514f24
) (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  sec_out_pkg::addr_t      awaddr_i,
   input  logic                    awvalid_i,
   output logic                    awready_o,
   input  sec_out_pkg::wide_data_t wdata_i,
   input  sec_out_pkg::wide_strb_t wstrb_i,
   input  logic                    wvalid_i,
   output logic                    wready_o,
   output sec_out_pkg::resp_t      bresp_o,
   output logic                    bvalid_o,
   input  logic                    bready_i,
   input  sec_out_pkg::addr_t      araddr_i,
   input  logic                    arvalid_i,
   output logic                    arready_o,
   output sec_out_pkg::wide_data_t rdata_o,
   output sec_out_pkg::resp_t      rresp_o,
   output logic                    rvalid_o,
   input  logic                    rready_i
);
   import sec_out_pkg::*;

   logic [7:0]  mem_bytes [addr_t];
   addr_t       aw_q[$];
   wide_data_t  wd_q[$];
   wide_strb_t  ws_q[$];
   wide_data_t  rd_q[$];
   int unsigned b_left;
   int unsigned aw_wait;
   int unsigned w_wait;
   int unsigned ar_wait;
   int unsigned b_wait;
   int unsigned r_wait;
   integer      seed;

   initial begin
      seed      = Seed;
      awready_o = 1'b0;
      wready_o  = 1'b0;
      arready_o = 1'b0;
      bvalid_o  = 1'b0;
      rvalid_o  = 1'b0;
      bresp_o   = RespOkay;
      rresp_o   = RespOkay;
      rdata_o   = '0;
   end

   function automatic int unsigned draw_stall();
      return $unsigned($random(seed)) % 4;
   endfunction

   // Unwritten bytes read as zero
   function automatic wide_data_t read_word(addr_t addr);
      wide_data_t word;
      addr_t      base;
      base = addr & ~addr_t'(7);
      for (int i = 0; i < 8; i++) begin
         word[8*i +: 8] = mem_bytes.exists(base + i) ? mem_bytes[base + i] : 8'h00;
      end
      return word;
   endfunction

   task automatic write_word(addr_t addr, wide_data_t data, wide_strb_t strb);
      addr_t base;
      base = addr & ~addr_t'(7);
      for (int i = 0; i < 8; i++) begin
         if (strb[i]) mem_bytes[base + i] = data[8*i +: 8];
      end
   endtask

   // Ready drops for 0 to 3 cycles after each transfer
   task automatic pace(input logic fired, inout logic rdy, inout int unsigned cnt);
      if (fired) begin
         cnt = draw_stall();
      end else if (cnt != 0) begin
         cnt--;
      end
      rdy = (cnt == 0);
   endtask

   always @(posedge clk_i) begin : step
      logic aw_hs;
      logic w_hs;
      logic ar_hs;
      logic b_hs;
      logic r_hs;
      aw_hs = awvalid_i && awready_o;
      w_hs  = wvalid_i && wready_o;
      ar_hs = arvalid_i && arready_o;
      b_hs  = bvalid_o && bready_i;
      r_hs  = rvalid_o && rready_i;
      if (aw_hs) aw_q.push_back(awaddr_i);
      if (w_hs) begin
         wd_q.push_back(wdata_i);
         ws_q.push_back(wstrb_i);
      end
      if (ar_hs) rd_q.push_back(read_word(araddr_i));
      if (b_hs) b_left--;
      if (r_hs) void'(rd_q.pop_front());
      while (aw_q.size() != 0 && wd_q.size() != 0) begin
         write_word(aw_q.pop_front(), wd_q.pop_front(), ws_q.pop_front());
         b_left++;
      end
      #1;
      if (reset_i) begin
         aw_q.delete();
         wd_q.delete();
         ws_q.delete();
         rd_q.delete();
         b_left    = 0;
         aw_wait   = 0;
         w_wait    = 0;
         ar_wait   = 0;
         b_wait    = 0;
         r_wait    = 0;
         awready_o = 1'b0;
         wready_o  = 1'b0;
         arready_o = 1'b0;
         bvalid_o  = 1'b0;
         rvalid_o  = 1'b0;
      end else begin
         pace(aw_hs, awready_o, aw_wait);
         pace(w_hs, wready_o, w_wait);
         pace(ar_hs, arready_o, ar_wait);
         if (b_hs) begin
            bvalid_o = 1'b0;
            b_wait   = draw_stall();
         end
         if (!bvalid_o && b_left != 0) begin
            if (b_wait == 0) bvalid_o = 1'b1;
            else b_wait--;
         end
         if (r_hs) begin
            rvalid_o = 1'b0;
            r_wait   = draw_stall();
         end
         if (!rvalid_o && rd_q.size() != 0) begin
            if (r_wait == 0) begin
               rvalid_o = 1'b1;
               rdata_o  = rd_q[0];
            end else begin
               r_wait--;
            end
         end
      end
   end

endmodule

/* rtl/sec_out_port.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Outbound port of the secure subsystem, 32-bit AXI4-Lite in,
// 64-bit AXI4-Lite out, with a clean isolate on request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sec_out_port #(
   parameter int unsigned SyncStages = 3,
   parameter int unsigned MaxPending = 8,
   parameter int unsigned LaneDepth  = 8
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  logic                      isolate_i,
   output logic                      isolated_o,
   // Root-of-trust side
   input  sec_out_pkg::addr_t        s_axil_awaddr_i,
   input  logic                      s_axil_awvalid_i,
   output logic                      s_axil_awready_o,
   input  sec_out_pkg::narrow_data_t s_axil_wdata_i,
   input  sec_out_pkg::narrow_strb_t s_axil_wstrb_i,
   input  logic                      s_axil_wvalid_i,
   output logic                      s_axil_wready_o,
   output sec_out_pkg::resp_t        s_axil_bresp_o,
   output logic                      s_axil_bvalid_o,
   input  logic                      s_axil_bready_i,
   input  sec_out_pkg::addr_t        s_axil_araddr_i,
   input  logic                      s_axil_arvalid_i,
   output logic                      s_axil_arready_o,
   output sec_out_pkg::narrow_data_t s_axil_rdata_o,
   output sec_out_pkg::resp_t        s_axil_rresp_o,
   output logic                      s_axil_rvalid_o,
   input  logic                      s_axil_rready_i,
   // Host side
   output sec_out_pkg::addr_t        m_axil_awaddr_o,
   output logic                      m_axil_awvalid_o,
   input  logic                      m_axil_awready_i,
   output sec_out_pkg::wide_data_t   m_axil_wdata_o,
   output sec_out_pkg::wide_strb_t   m_axil_wstrb_o,
   output logic                      m_axil_wvalid_o,
   input  logic                      m_axil_wready_i,
   input  sec_out_pkg::resp_t        m_axil_bresp_i,
   input  logic                      m_axil_bvalid_i,
   output logic                      m_axil_bready_o,
   output sec_out_pkg::addr_t        m_axil_araddr_o,
   output logic                      m_axil_arvalid_o,
   input  logic                      m_axil_arready_i,
   input  sec_out_pkg::wide_data_t   m_axil_rdata_i,
   input  sec_out_pkg::resp_t        m_axil_rresp_i,
   input  logic                      m_axil_rvalid_i,
   output logic                      m_axil_rready_o
);
   import sec_out_pkg::*;

   // Wide bus between upsizer and isolation stage
   addr_t      up_awaddr;
   logic       up_awvalid;
   logic       up_awready;
   wide_data_t up_wdata;
   wide_strb_t up_wstrb;
   logic       up_wvalid;
   logic       up_wready;
   resp_t      up_bresp;
   logic       up_bvalid;
   logic       up_bready;
   addr_t      up_araddr;
   logic       up_arvalid;
   logic       up_arready;
   wide_data_t up_rdata;
   resp_t      up_rresp;
   logic       up_rvalid;
   logic       up_rready;

   axil_upsizer #(
      .LaneDepth        ( LaneDepth  )
   ) i_axil_upsizer (
      .m_axil_awaddr_o  ( up_awaddr  ),
      .m_axil_awvalid_o ( up_awvalid ),
      .m_axil_awready_i ( up_awready ),
      .m_axil_wdata_o   ( up_wdata   ),
      .m_axil_wstrb_o   ( up_wstrb   ),
      .m_axil_wvalid_o  ( up_wvalid  ),
      .m_axil_wready_i  ( up_wready  ),
      .m_axil_bresp_i   ( up_bresp   ),
      .m_axil_bvalid_i  ( up_bvalid  ),
      .m_axil_bready_o  ( up_bready  ),
      .m_axil_araddr_o  ( up_araddr  ),
      .m_axil_arvalid_o ( up_arvalid ),
      .m_axil_arready_i ( up_arready ),
      .m_axil_rdata_i   ( up_rdata   ),
      .m_axil_rresp_i   ( up_rresp   ),
      .m_axil_rvalid_i  ( up_rvalid  ),
      .m_axil_rready_o  ( up_rready  ),
      .*
   );

   axil_isolate #(
      .SyncStages       ( SyncStages ),
      .MaxPending       ( MaxPending )
   ) i_axil_isolate (
      .s_axil_awaddr_i  ( up_awaddr  ),
      .s_axil_awvalid_i ( up_awvalid ),
      .s_axil_awready_o ( up_awready ),
      .s_axil_wdata_i   ( up_wdata   ),
      .s_axil_wstrb_i   ( up_wstrb   ),
      .s_axil_wvalid_i  ( up_wvalid  ),
      .s_axil_wready_o  ( up_wready  ),
      .s_axil_bresp_o   ( up_bresp   ),
      .s_axil_bvalid_o  ( up_bvalid  ),
      .s_axil_bready_i  ( up_bready  ),
      .s_axil_araddr_i  ( up_araddr  ),
      .s_axil_arvalid_i ( up_arvalid ),
      .s_axil_arready_o ( up_arready ),
      .s_axil_rdata_o   ( up_rdata   ),
      .s_axil_rresp_o   ( up_rresp   ),
      .s_axil_rvalid_o  ( up_rvalid  ),
      .s_axil_rready_i  ( up_rready  ),
      .*
   );

endmodule

/* rtl/isolate/axil_isolate.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite isolation stage, drains in-flight traffic on an
// isolate request and then answers new requests locally
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axil_isolate #(
   parameter int unsigned SyncStages = 3,
   parameter int unsigned MaxPending = 8
) (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    isolate_i,
   output logic                    isolated_o,
   input  sec_out_pkg::addr_t      s_axil_awaddr_i,
   input  logic                    s_axil_awvalid_i,
   output logic                    s_axil_awready_o,
   input  sec_out_pkg::wide_data_t s_axil_wdata_i,
   input  sec_out_pkg::wide_strb_t s_axil_wstrb_i,
   input  logic                    s_axil_wvalid_i,
   output logic                    s_axil_wready_o,
   output sec_out_pkg::resp_t      s_axil_bresp_o,
   output logic                    s_axil_bvalid_o,
   input  logic                    s_axil_bready_i,
   input  sec_out_pkg::addr_t      s_axil_araddr_i,
   input  logic                    s_axil_arvalid_i,
   output logic                    s_axil_arready_o,
   output sec_out_pkg::wide_data_t s_axil_rdata_o,
   output sec_out_pkg::resp_t      s_axil_rresp_o,
   output logic                    s_axil_rvalid_o,
   input  logic                    s_axil_rready_i,
   output sec_out_pkg::addr_t      m_axil_awaddr_o,
   output logic                    m_axil_awvalid_o,
   input  logic                    m_axil_awready_i,
   output sec_out_pkg::wide_data_t m_axil_wdata_o,
   output sec_out_pkg::wide_strb_t m_axil_wstrb_o,
   output logic                    m_axil_wvalid_o,
   input  logic                    m_axil_wready_i,
   input  sec_out_pkg::resp_t      m_axil_bresp_i,
   input  logic                    m_axil_bvalid_i,
   output logic                    m_axil_bready_o,
   output sec_out_pkg::addr_t      m_axil_araddr_o,
   output logic                    m_axil_arvalid_o,
   input  logic                    m_axil_arready_i,
   input  sec_out_pkg::wide_data_t m_axil_rdata_i,
   input  sec_out_pkg::resp_t      m_axil_rresp_i,
   input  logic                    m_axil_rvalid_i,
   output logic                    m_axil_rready_o
);
   import sec_out_pkg::*;

   localparam int unsigned CntW = $clog2(MaxPending + 1);
   typedef logic [CntW-1:0] cnt_t;

   logic [SyncStages-1:0] iso_sync_q;
   logic                  iso_req;
   iso_state_e            state_q;
   iso_state_e            state_d;
   cnt_t                  w_cnt_q;
   cnt_t                  r_cnt_q;
   logic                  passing;
   logic                  isolated;
   logic                  drained;
   logic                  term_idle;
   logic                  allow_aw;
   logic                  allow_ar;
   logic                  aw_held_q;
   logic                  w_held_q;
   logic                  b_term_q;
   logic                  r_term_q;
   logic                  t_aw_fire;
   logic                  t_w_fire;
   logic                  w_inc;
   logic                  w_dec;
   logic                  r_inc;
   logic                  r_dec;

   // Request synchronizer that resets to isolated
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         iso_sync_q <= '1;
      end else begin
         iso_sync_q <= (iso_sync_q << 1) | SyncStages'(isolate_i);
      end
   end
   assign iso_req = iso_sync_q[SyncStages-1];

   assign passing   = (state_q == Passing);
   assign isolated  = (state_q == Isolated);
   assign drained   = (w_cnt_q == '0) && (r_cnt_q == '0);
   assign term_idle = !aw_held_q && !w_held_q && !b_term_q && !r_term_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         Passing: begin
            if (iso_req) begin
               state_d = drained ? Isolated : Draining;
            end
         end
         Draining: begin
            if (!iso_req) begin
               state_d = Passing;
            end else if (drained) begin
               state_d = Isolated;
            end
         end
         Isolated: begin
            if (!iso_req && term_idle) begin
               state_d = Passing;
            end
         end
         default: state_d = Isolated;
      endcase
   end

   assign isolated_o = isolated;

   // New requests only in Passing and below the pending limit
   assign allow_aw = passing && !iso_req && (w_cnt_q != cnt_t'(MaxPending));
   assign allow_ar = passing && !iso_req && (r_cnt_q != cnt_t'(MaxPending));

   assign m_axil_awaddr_o  = s_axil_awaddr_i;
   assign m_axil_awvalid_o = s_axil_awvalid_i && allow_aw;
   assign s_axil_awready_o = isolated ? (!aw_held_q && !b_term_q)
                                      : (m_axil_awready_i && allow_aw);
   assign m_axil_wdata_o   = s_axil_wdata_i;
   assign m_axil_wstrb_o   = s_axil_wstrb_i;
   assign m_axil_wvalid_o  = s_axil_wvalid_i && !isolated;
   assign s_axil_wready_o  = isolated ? (!w_held_q && !b_term_q) : m_axil_wready_i;
   assign s_axil_bresp_o   = isolated ? RespDecerr : m_axil_bresp_i;
   assign s_axil_bvalid_o  = isolated ? b_term_q : m_axil_bvalid_i;
   assign m_axil_bready_o  = s_axil_bready_i && !isolated;

   assign m_axil_araddr_o  = s_axil_araddr_i;
   assign m_axil_arvalid_o = s_axil_arvalid_i && allow_ar;
   assign s_axil_arready_o = isolated ? !r_term_q : (m_axil_arready_i && allow_ar);
   assign s_axil_rdata_o   = isolated ? '0 : m_axil_rdata_i;
   assign s_axil_rresp_o   = isolated ? RespDecerr : m_axil_rresp_i;
   assign s_axil_rvalid_o  = isolated ? r_term_q : m_axil_rvalid_i;
   assign m_axil_rready_o  = s_axil_rready_i && !isolated;

   assign t_aw_fire = isolated && s_axil_awvalid_i && s_axil_awready_o;
   assign t_w_fire  = isolated && s_axil_wvalid_i && s_axil_wready_o;

   assign w_inc = m_axil_awvalid_o && m_axil_awready_i;
   assign w_dec = m_axil_bvalid_i && m_axil_bready_o;
   assign r_inc = m_axil_arvalid_o && m_axil_arready_i;
   assign r_dec = m_axil_rvalid_i && m_axil_rready_o;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q   <= Isolated;
         w_cnt_q   <= '0;
         r_cnt_q   <= '0;
         aw_held_q <= 1'b0;
         w_held_q  <= 1'b0;
         b_term_q  <= 1'b0;
         r_term_q  <= 1'b0;
      end else begin
         state_q <= state_d;
         w_cnt_q <= w_cnt_q + cnt_t'(w_inc) - cnt_t'(w_dec);
         r_cnt_q <= r_cnt_q + cnt_t'(r_inc) - cnt_t'(r_dec);
         if (b_term_q && s_axil_bready_i) begin
            b_term_q <= 1'b0;
         end
         // Local B once both halves of a write are in
         if ((aw_held_q || t_aw_fire) && (w_held_q || t_w_fire)) begin
            aw_held_q <= 1'b0;
            w_held_q  <= 1'b0;
            b_term_q  <= 1'b1;
         end else begin
            aw_held_q <= aw_held_q || t_aw_fire;
            w_held_q  <= w_held_q || t_w_fire;
         end
         if (isolated && s_axil_arvalid_i && s_axil_arready_o) begin
            r_term_q <= 1'b1;
         end else if (r_term_q && s_axil_rready_i) begin
            r_term_q <= 1'b0;
         end
      end
   end

   a_no_cnt_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
      !((w_cnt_q == '0) && w_dec) && !((r_cnt_q == '0) && r_dec));

   // Isolated only after a full drain, with the host side silent
   a_quiet_when_isolated: assert property (@(posedge clk_i) disable iff (reset_i)
      isolated_o |-> drained && !(m_axil_awvalid_o || m_axil_wvalid_o || m_axil_arvalid_o));

endmodule

/* rtl/upsizer/axil_upsizer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite width converter, 32-bit slave port onto a 64-bit
// master port, zero added latency on every channel
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axil_upsizer #(
   parameter int unsigned LaneDepth = 8
) (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  sec_out_pkg::addr_t        s_axil_awaddr_i,
   input  logic                      s_axil_awvalid_i,
   output logic                      s_axil_awready_o,
   input  sec_out_pkg::narrow_data_t s_axil_wdata_i,
   input  sec_out_pkg::narrow_strb_t s_axil_wstrb_i,
   input  logic                      s_axil_wvalid_i,
   output logic                      s_axil_wready_o,
   output sec_out_pkg::resp_t        s_axil_bresp_o,
   output logic                      s_axil_bvalid_o,
   input  logic                      s_axil_bready_i,
   input  sec_out_pkg::addr_t        s_axil_araddr_i,
   input  logic                      s_axil_arvalid_i,
   output logic                      s_axil_arready_o,
   output sec_out_pkg::narrow_data_t s_axil_rdata_o,
   output sec_out_pkg::resp_t        s_axil_rresp_o,
   output logic                      s_axil_rvalid_o,
   input  logic                      s_axil_rready_i,
   output sec_out_pkg::addr_t        m_axil_awaddr_o,
   output logic                      m_axil_awvalid_o,
   input  logic                      m_axil_awready_i,
   output sec_out_pkg::wide_data_t   m_axil_wdata_o,
   output sec_out_pkg::wide_strb_t   m_axil_wstrb_o,
   output logic                      m_axil_wvalid_o,
   input  logic                      m_axil_wready_i,
   input  sec_out_pkg::resp_t        m_axil_bresp_i,
   input  logic                      m_axil_bvalid_i,
   output logic                      m_axil_bready_o,
   output sec_out_pkg::addr_t        m_axil_araddr_o,
   output logic                      m_axil_arvalid_o,
   input  logic                      m_axil_arready_i,
   input  sec_out_pkg::wide_data_t   m_axil_rdata_i,
   input  sec_out_pkg::resp_t        m_axil_rresp_i,
   input  logic                      m_axil_rvalid_i,
   output logic                      m_axil_rready_o
);
   import sec_out_pkg::*;

   localparam int unsigned PtrW    = (LaneDepth > 1) ? $clog2(LaneDepth) : 1;
   localparam int unsigned CntW    = $clog2(LaneDepth + 1);
   localparam int unsigned NarrowW = $bits(narrow_data_t);

   // Index 0 is the write lane queue, index 1 the read lane queue
   logic [1:0] q_push;
   logic [1:0] q_pop;
   logic [1:0] q_din;
   logic [1:0] q_head;
   logic [1:0] q_empty;
   logic [1:0] q_full;

   logic aw_fire;
   logic w_lane_ok;
   logic w_lane;
   logic r_lane;

   for (genvar q = 0; q < 2; q++) begin : g_lane_q
      logic [LaneDepth-1:0] mem;
      logic [PtrW-1:0]      wr_ptr;
      logic [PtrW-1:0]      rd_ptr;
      logic [CntW-1:0]      count;

      always_ff @(posedge clk_i) begin
         if (q_push[q]) begin
            mem[wr_ptr] <= q_din[q];
         end
      end

      always_ff @(posedge clk_i) begin
         if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
         end else begin
            if (q_push[q]) begin
               wr_ptr <= (wr_ptr == PtrW'(LaneDepth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q_pop[q]) begin
               rd_ptr <= (rd_ptr == PtrW'(LaneDepth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CntW'(q_push[q]) - CntW'(q_pop[q]);
         end
      end

      assign q_head[q]  = mem[rd_ptr];
      assign q_empty[q] = (count == '0);
      assign q_full[q]  = (count == CntW'(LaneDepth));
   end

   // Write address stalls only on a full lane queue
   assign m_axil_awaddr_o  = s_axil_awaddr_i;
   assign m_axil_awvalid_o = s_axil_awvalid_i && !q_full[0];
   assign s_axil_awready_o = m_axil_awready_i && !q_full[0];
   assign aw_fire          = s_axil_awvalid_i && s_axil_awready_o;
   assign q_push[0]        = aw_fire;
   assign q_din[0]         = s_axil_awaddr_i[LaneSel];

   // W rides along with its AW when the queue is empty
   assign w_lane_ok       = !q_empty[0] || aw_fire;
   assign w_lane          = q_empty[0] ? s_axil_awaddr_i[LaneSel] : q_head[0];
   assign m_axil_wdata_o  = {2{s_axil_wdata_i}};
   assign m_axil_wstrb_o  = w_lane ? {s_axil_wstrb_i, narrow_strb_t'(0)}
                                   : {narrow_strb_t'(0), s_axil_wstrb_i};
   assign m_axil_wvalid_o = s_axil_wvalid_i && w_lane_ok;
   assign s_axil_wready_o = m_axil_wready_i && w_lane_ok;
   assign q_pop[0]        = s_axil_wvalid_i && s_axil_wready_o;

   assign s_axil_bresp_o  = m_axil_bresp_i;
   assign s_axil_bvalid_o = m_axil_bvalid_i;
   assign m_axil_bready_o = s_axil_bready_i;

   assign m_axil_araddr_o  = s_axil_araddr_i;
   assign m_axil_arvalid_o = s_axil_arvalid_i && !q_full[1];
   assign s_axil_arready_o = m_axil_arready_i && !q_full[1];
   assign q_push[1]        = s_axil_arvalid_i && s_axil_arready_o;
   assign q_din[1]         = s_axil_araddr_i[LaneSel];

   // Half of the wide read word picked by the oldest read
   assign r_lane          = q_head[1];
   assign s_axil_rdata_o  = m_axil_rdata_i[NarrowW*r_lane +: NarrowW];
   assign s_axil_rresp_o  = m_axil_rresp_i;
   assign s_axil_rvalid_o = m_axil_rvalid_i;
   assign m_axil_rready_o = s_axil_rready_i;
   assign q_pop[1]        = m_axil_rvalid_i && m_axil_rready_o;

   a_lane_q_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
      !(q_push[0] && q_full[0] && !q_pop[0]) && !(q_push[1] && q_full[1] && !q_pop[1]));

   // A response must always find its lane bit queued
   a_lane_q_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
      !(q_pop[0] && q_empty[0] && !q_push[0]) && !(q_pop[1] && q_empty[1]));

endmodule

/* common/sec_out_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, response codes and FSM states of the
// outbound port, imported by the upsizer and isolation stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sec_out_pkg;

   // Byte address, same on both sides
   typedef logic [31:0] addr_t;

   // Upstream port from the root of trust
   typedef logic [31:0] narrow_data_t;
   typedef logic [3:0]  narrow_strb_t;

   // Downstream port towards the host
   typedef logic [63:0] wide_data_t;
   typedef logic [7:0]  wide_strb_t;

   typedef logic [1:0]  resp_t;

   localparam resp_t RespOkay   = 2'b00;
   localparam resp_t RespDecerr = 2'b11;

   // Picks the upper 32-bit half of a wide word
   localparam int unsigned LaneSel = 2;

   typedef enum logic [1:0] {
      Passing,
      Draining,
      Isolated
   } iso_state_e;

endpackage
